// ==== verilog/accel_pkg.sv ====
package accel_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// tag number carried by every memory command
	typedef logic [7:0] command_tag_t;

	// compute unit index
	typedef logic [3:0] cu_id_t;

	// command kind, read or write, the rest reserved
	typedef logic [1:0] command_type_t;

	//////////////////////////////
	// owner record per tag
	//////////////////////////////

	// cu id sits above the command type
	localparam int line_cu_msb   = 5;
	localparam int line_type_msb = 1;

	// {cu_id_t, command_type_t}
	typedef logic [line_cu_msb:0] tag_line_t;

	//////////////////////////////
	// tag pool fsm
	//////////////////////////////

	typedef enum logic [1:0] {
		TAG_BUFFER_RESET,
		TAG_BUFFER_INIT,
		TAG_BUFFER_READY
	} tag_buffer_state;

endpackage

// ==== verilog/fifo.sv ====
module fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             almost_full,
	input  logic             pop,
	output logic             valid,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             do_push;
	logic             do_pop;

	// pop on empty is dropped, push on full only with a pop
	assign do_pop  = pop & ~empty;
	assign do_push = push & (~full | do_pop);

	assign empty       = (count == '0);
	assign full        = (count == CW'(DEPTH));
	assign almost_full = (count >= CW'(DEPTH - 1));

	// head word shows without a pop
	assign valid    = ~empty;
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// pointers wrap at depth, not at a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== verilog/ram_2xrd.sv ====
module ram_2xrd #(
	parameter int WIDTH = 6,
	parameter int DEPTH = 16
) (
	input  logic                                     clock,
	input  logic                                     we,
	input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] wr_addr,
	input  logic [WIDTH-1:0]                         data_in,
	input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] rd_addr1,
	output logic [WIDTH-1:0]                         data_out1,
	input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] rd_addr2,
	output logic [WIDTH-1:0]                         data_out2
);

	logic [WIDTH-1:0] mem [DEPTH];

	// single write port
	always_ff @(posedge clock) begin
		if (we)
			mem[wr_addr] <= data_in;
	end

	// two independent async reads
	assign data_out1 = mem[rd_addr1];
	assign data_out2 = mem[rd_addr2];

endmodule

// ==== verilog/tag_control.sv ====
module tag_control #(
	parameter int TAG_COUNT = 16
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled_in,
	input  logic                    tag_response_valid,
	input  accel_pkg::command_tag_t response_tag,
	output accel_pkg::tag_line_t    response_tag_id_out,
	input  accel_pkg::command_tag_t data_read_tag,
	output accel_pkg::tag_line_t    data_read_tag_id_out,
	input  logic                    tag_command_valid,
	input  accel_pkg::tag_line_t    tag_command_id,
	output accel_pkg::command_tag_t command_tag_out,
	output logic                    tag_buffer_ready
);

	import accel_pkg::*;

	localparam int TAG_AW = (TAG_COUNT > 1) ? $clog2(TAG_COUNT) : 1;

	logic            enabled;
	tag_buffer_state current_state;
	tag_buffer_state next_state;
	command_tag_t    tag_counter;
	command_tag_t    fifo_data_in;
	command_tag_t    head_tag;
	logic            fifo_push;
	logic            fifo_pop;
	logic            fifo_full;
	logic            fifo_valid;
	logic            fifo_empty;
	logic            issue;

	//////////////////////////////
	// enable and pool fsm
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	// disable forces reset, pool gets rebuilt on the way back
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			current_state <= TAG_BUFFER_RESET;
		else if (!enabled)
			current_state <= TAG_BUFFER_RESET;
		else
			current_state <= next_state;
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			// leave once old tags are drained
			TAG_BUFFER_RESET: if (fifo_empty) next_state = TAG_BUFFER_INIT;
			// every tag pushed
			TAG_BUFFER_INIT:  if (fifo_full) next_state = TAG_BUFFER_READY;
			TAG_BUFFER_READY: next_state = TAG_BUFFER_READY;
			default:          next_state = TAG_BUFFER_RESET;
		endcase
	end

	// init counter, tag numbers 0 upwards
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			tag_counter <= '0;
		else if (current_state == TAG_BUFFER_RESET)
			tag_counter <= '0;
		else if (current_state == TAG_BUFFER_INIT && !fifo_full)
			tag_counter <= tag_counter + 1'b1;
	end

	//////////////////////////////
	// fifo steering
	//////////////////////////////

	assign issue = tag_command_valid & fifo_valid & (current_state == TAG_BUFFER_READY);

	always_comb begin
		fifo_push    = 1'b0;
		fifo_pop     = 1'b0;
		fifo_data_in = response_tag;
		case (current_state)
			// drain leftovers from before the disable
			TAG_BUFFER_RESET: fifo_pop = ~fifo_empty;
			TAG_BUFFER_INIT: begin
				fifo_push    = ~fifo_full;
				fifo_data_in = tag_counter;
			end
			// returned tags in, issued tags out
			TAG_BUFFER_READY: begin
				fifo_push = tag_response_valid;
				fifo_pop  = issue;
			end
			default: fifo_push = 1'b0;
		endcase
	end

	assign tag_buffer_ready = (current_state == TAG_BUFFER_READY) & ~fifo_empty;
	assign command_tag_out  = head_tag;

	fifo #(
		.WIDTH($bits(command_tag_t)),
		.DEPTH(TAG_COUNT)
	) tag_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (fifo_push),
		.data_in    (fifo_data_in),
		.full       (fifo_full),
		.almost_full(),
		.pop        (fifo_pop),
		.valid      (fifo_valid),
		.data_out   (head_tag),
		.empty      (fifo_empty)
	);

	//////////////////////////////
	// tag to owner memory
	//////////////////////////////

	// owner written at the head tag on issue
	ram_2xrd #(
		.WIDTH($bits(tag_line_t)),
		.DEPTH(TAG_COUNT)
	) tag_ram (
		.clock    (clock),
		.we       (issue),
		.wr_addr  (head_tag[TAG_AW-1:0]),
		.data_in  (tag_command_id),
		.rd_addr1 (response_tag[TAG_AW-1:0]),
		.data_out1(response_tag_id_out),
		.rd_addr2 (data_read_tag[TAG_AW-1:0]),
		.data_out2(data_read_tag_id_out)
	);

endmodule

// ==== verilog/cu_credit_unit.sv ====
module cu_credit_unit #(
	parameter int CU_CREDITS = 3
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     req,
	input  accel_pkg::command_type_t req_type,
	output logic                     req_ready,
	output logic                     pending,
	output accel_pkg::command_type_t pending_type,
	input  logic                     grant,
	input  logic                     credit_return
);

	localparam int CW = $clog2(CU_CREDITS + 1);

	logic          held;
	logic [CW-1:0] outstanding;

	// one slot only
	assign req_ready = ~held;
	// held request waits while credits run out
	assign pending   = held & (outstanding < CW'(CU_CREDITS));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			held <= 1'b0;
		else if (grant)
			held <= 1'b0;
		else if (req && !held)
			held <= 1'b1;
	end

	// type captured with the request
	always_ff @(posedge clock) begin
		if (req && !held)
			pending_type <= req_type;
	end

	// grant and return together cancel
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else begin
			case ({grant, credit_return})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

endmodule

// ==== verilog/command_arbiter.sv ====
module command_arbiter #(
	parameter int CU_COUNT = 4
) (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic [CU_COUNT-1:0]                     pending,
	input  accel_pkg::command_type_t [CU_COUNT-1:0] pending_type,
	input  logic                                    tag_buffer_ready,
	output logic [CU_COUNT-1:0]                     grant,
	output logic                                    tag_command_valid,
	output accel_pkg::tag_line_t                    tag_command_id
);

	import accel_pkg::*;

	localparam int IW = (CU_COUNT > 1) ? $clog2(CU_COUNT) : 1;

	logic [IW-1:0] rr_ptr;
	logic [IW-1:0] winner;
	logic          found;

	// first pending unit at or after the pointer
	always_comb begin : pick
		int unsigned idx;
		found  = 1'b0;
		winner = '0;
		for (int i = 0; i < CU_COUNT; i++) begin
			idx = int'(rr_ptr) + i;
			if (idx >= CU_COUNT)
				idx = idx - CU_COUNT;
			if (!found && pending[idx]) begin
				found  = 1'b1;
				winner = IW'(idx);
			end
		end
	end

	// no tags, no grant
	assign tag_command_valid = found & tag_buffer_ready;

	always_comb begin
		grant         = '0;
		grant[winner] = tag_command_valid;
	end

	// owner record of the winner
	always_comb begin
		tag_command_id                            = '0;
		tag_command_id[line_cu_msb:line_type_msb+1] = cu_id_t'(winner);
		tag_command_id[line_type_msb:0]           = pending_type[winner];
	end

	// priority moves just past the last grant
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			rr_ptr <= '0;
		else if (tag_command_valid)
			rr_ptr <= (winner == IW'(CU_COUNT - 1)) ? '0 : winner + 1'b1;
	end

endmodule

// ==== verilog/response_router.sv ====
module response_router #(
	parameter int CU_COUNT = 4
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     tag_response_valid,
	input  accel_pkg::tag_line_t     response_line,
	output logic [CU_COUNT-1:0]      response_done,
	output accel_pkg::command_type_t response_type,
	output logic [CU_COUNT-1:0]      credit_return
);

	import accel_pkg::*;

	cu_id_t              owner_cu;
	logic [CU_COUNT-1:0] done_next;
	logic [CU_COUNT-1:0] done_q;

	assign owner_cu = response_line[line_cu_msb:line_type_msb+1];

	// one-hot owner decode
	always_comb begin
		for (int i = 0; i < CU_COUNT; i++)
			done_next[i] = tag_response_valid && (owner_cu == cu_id_t'(i));
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			done_q <= '0;
		else
			done_q <= done_next;
	end

	always_ff @(posedge clock) begin
		if (tag_response_valid)
			response_type <= response_line[line_type_msb:0];
	end

	// completion doubles as the credit back
	assign response_done = done_q;
	assign credit_return = done_q;

endmodule

// ==== verilog/tag_subsystem_top.sv ====
module tag_subsystem_top #(
	parameter int TAG_COUNT  = 16,
	parameter int CU_COUNT   = 4,
	parameter int CU_CREDITS = 3
) (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    enabled_in,
	input  logic [CU_COUNT-1:0]                     cu_req,
	input  accel_pkg::command_type_t [CU_COUNT-1:0] cu_req_type,
	output logic [CU_COUNT-1:0]                     cu_req_ready,
	output logic                                    command_valid,
	output accel_pkg::command_tag_t                 command_tag,
	output accel_pkg::cu_id_t                       command_cu,
	output accel_pkg::command_type_t                command_type,
	input  logic                                    tag_response_valid,
	input  accel_pkg::command_tag_t                 response_tag,
	output logic [CU_COUNT-1:0]                     response_done,
	output accel_pkg::command_type_t                response_type,
	input  accel_pkg::command_tag_t                 data_read_tag,
	output accel_pkg::cu_id_t                       data_read_cu,
	output accel_pkg::command_type_t                data_read_type,
	output logic                                    tags_ready
);

	import accel_pkg::*;

	logic [CU_COUNT-1:0]          pending;
	command_type_t [CU_COUNT-1:0] pending_type;
	logic [CU_COUNT-1:0]          grant;
	logic [CU_COUNT-1:0]          credit_return;
	logic                         tag_command_valid;
	logic                         tag_buffer_ready;
	tag_line_t                    tag_command_id;
	tag_line_t                    response_line;
	tag_line_t                    data_read_line;

	//////////////////////////////
	// per unit credit
	//////////////////////////////

	for (genvar i = 0; i < CU_COUNT; i++) begin : g_cu
		cu_credit_unit #(
			.CU_CREDITS(CU_CREDITS)
		) credit (
			.clock        (clock),
			.rstn         (rstn),
			.req          (cu_req[i]),
			.req_type     (cu_req_type[i]),
			.req_ready    (cu_req_ready[i]),
			.pending      (pending[i]),
			.pending_type (pending_type[i]),
			.grant        (grant[i]),
			.credit_return(credit_return[i])
		);
	end

	//////////////////////////////
	// arbitration and tags
	//////////////////////////////

	command_arbiter #(
		.CU_COUNT(CU_COUNT)
	) arbiter (
		.clock            (clock),
		.rstn             (rstn),
		.pending          (pending),
		.pending_type     (pending_type),
		.tag_buffer_ready (tag_buffer_ready),
		.grant            (grant),
		.tag_command_valid(tag_command_valid),
		.tag_command_id   (tag_command_id)
	);

	tag_control #(
		.TAG_COUNT(TAG_COUNT)
	) tags (
		.clock               (clock),
		.rstn                (rstn),
		.enabled_in          (enabled_in),
		.tag_response_valid  (tag_response_valid),
		.response_tag        (response_tag),
		.response_tag_id_out (response_line),
		.data_read_tag       (data_read_tag),
		.data_read_tag_id_out(data_read_line),
		.tag_command_valid   (tag_command_valid),
		.tag_command_id      (tag_command_id),
		.command_tag_out     (command_tag),
		.tag_buffer_ready    (tag_buffer_ready)
	);

	response_router #(
		.CU_COUNT(CU_COUNT)
	) router (
		.clock             (clock),
		.rstn              (rstn),
		.tag_response_valid(tag_response_valid),
		.response_line     (response_line),
		.response_done     (response_done),
		.response_type     (response_type),
		.credit_return     (credit_return)
	);

	// command fields split from the owner record
	assign command_valid  = tag_command_valid;
	assign command_cu     = tag_command_id[line_cu_msb:line_type_msb+1];
	assign command_type   = tag_command_id[line_type_msb:0];
	assign data_read_cu   = data_read_line[line_cu_msb:line_type_msb+1];
	assign data_read_type = data_read_line[line_type_msb:0];
	assign tags_ready     = tag_buffer_ready;

endmodule

// ==== bench/tag_subsystem_chk.sv ====
module tag_subsystem_chk #(
	parameter int CU_COUNT  = 4,
	parameter int TAG_COUNT = 16
) (
	input logic                clock,
	input logic                rstn,
	input logic                command_valid,
	input logic                tags_ready,
	input logic                tag_response_valid,
	input logic [CU_COUNT-1:0] response_done,
	input logic [CU_COUNT-1:0] cu_req_ready,
	input logic [CU_COUNT-1:0] grant
);

	// counts assertion failures for the testbench monitor
	int failures = 0;
	// tags out at memory, issued and not yet returned
	int in_flight;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			in_flight <= 0;
		else
			in_flight <= in_flight + int'(command_valid) - int'(tag_response_valid);
	end

	// ready flag only while some tag is still free
	assert property (@(posedge clock) disable iff (!rstn) tags_ready |-> in_flight < TAG_COUNT)
	else begin
		failures++;
		$error("tags_ready is high while every tag is in flight");
	end

	// each response completes exactly one unit, a cycle later
	assert property (@(posedge clock) disable iff (!rstn)
		tag_response_valid |=> $onehot(response_done))
	else begin
		failures++;
		$error("response did not give exactly one response_done bit");
	end

	// a slot reopens only after its grant
	assert property (@(posedge clock) disable iff (!rstn)
		(cu_req_ready & ~$past(cu_req_ready) & ~$past(grant)) == '0)
	else begin
		failures++;
		$error("cu_req_ready rose without a grant to that unit");
	end

endmodule

bind tag_subsystem_top tag_subsystem_chk #(
	.CU_COUNT (CU_COUNT),
	.TAG_COUNT(TAG_COUNT)
) chk (
	.clock             (clock),
	.rstn              (rstn),
	.command_valid     (command_valid),
	.tags_ready        (tags_ready),
	.tag_response_valid(tag_response_valid),
	.response_done     (response_done),
	.cu_req_ready      (cu_req_ready),
	.grant             (grant)
);

// ==== bench/tb_tag_subsystem.sv ====
module tb_tag_subsystem;

	import accel_pkg::*;

	localparam int TAG_COUNT  = 8;
	localparam int CU_COUNT   = 4;
	localparam int CU_CREDITS = 3;
	localparam int PERIOD     = 8;
	localparam int MAX_OPS    = 128;

	logic                         clock;
	logic                         rstn;
	logic                         enabled_in;
	logic [CU_COUNT-1:0]          cu_req;
	command_type_t [CU_COUNT-1:0] cu_req_type;
	logic [CU_COUNT-1:0]          cu_req_ready;
	logic                         command_valid;
	command_tag_t                 command_tag;
	cu_id_t                       command_cu;
	command_type_t                command_type;
	logic                         tag_response_valid;
	command_tag_t                 response_tag;
	logic [CU_COUNT-1:0]          response_done;
	command_type_t                response_type;
	command_tag_t                 data_read_tag;
	cu_id_t                       data_read_cu;
	command_type_t                data_read_type;
	logic                         tags_ready;

	//////////////////////////////
	// reference model state
	//////////////////////////////

	command_tag_t        free_q[$];
	tag_line_t           owner [TAG_COUNT];
	logic                issued [TAG_COUNT];
	int                  outstanding [CU_COUNT];
	logic                held [CU_COUNT];
	command_type_t       held_type [CU_COUNT];
	logic                ready_now [CU_COUNT];
	int                  rr;
	logic [CU_COUNT-1:0] exp_done;
	command_type_t       exp_type;
	logic                settled;
	logic [31:0]         lfsr;
	int                  failed;

	// trace ops, opcode plus up to three fields
	byte op_code [MAX_OPS];
	int  op_a [MAX_OPS];
	int  op_b [MAX_OPS];
	int  op_c [MAX_OPS];
	int  n_ops;
	bit  loaded;

	tag_subsystem_top #(
		.TAG_COUNT (TAG_COUNT),
		.CU_COUNT  (CU_COUNT),
		.CU_CREDITS(CU_CREDITS)
	) uut (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.cu_req            (cu_req),
		.cu_req_type       (cu_req_type),
		.cu_req_ready      (cu_req_ready),
		.command_valid     (command_valid),
		.command_tag       (command_tag),
		.command_cu        (command_cu),
		.command_type      (command_type),
		.tag_response_valid(tag_response_valid),
		.response_tag      (response_tag),
		.response_done     (response_done),
		.response_type     (response_type),
		.data_read_tag     (data_read_tag),
		.data_read_cu      (data_read_cu),
		.data_read_type    (data_read_type),
		.tags_ready        (tags_ready)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	//////////////////////////////
	// reporting and compares
	//////////////////////////////

	task automatic stop_run(input string msg);
		failed++;
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_tag(input command_tag_t got, input command_tag_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Error at time %0t: %s tag %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_line(input cu_id_t got_cu, input command_type_t got_type,
		input cu_id_t exp_cu, input command_type_t exp_ty, input string what);
		if (got_cu !== exp_cu || got_type !== exp_ty)
			stop_run($sformatf("Error at time %0t: %s unit %0d type %0d, expected %0d %0d",
				$time, what, got_cu, got_type, exp_cu, exp_ty));
	endtask

	task automatic check_type(input command_type_t got, input command_type_t exp,
		input string what);
		if (got !== exp)
			stop_run($sformatf("Error at time %0t: %s %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_done(input logic [CU_COUNT-1:0] got, input logic [CU_COUNT-1:0] exp,
		input string what);
		if (got !== exp)
			stop_run($sformatf("Error at time %0t: %s %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Error at time %0t: %s %b, expected %b", $time, what, got, exp));
	endtask

	// galois lfsr, one step per bit
	function automatic logic lfsr_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'hA300_0000;
		return b;
	endfunction

	// round robin from the unit after the last grant
	function automatic int pick_winner();
		int idx;
		for (int i = 0; i < CU_COUNT; i++) begin
			idx = (rr + i) % CU_COUNT;
			if (held[idx] && outstanding[idx] < CU_CREDITS)
				return idx;
		end
		return -1;
	endfunction

	//////////////////////////////
	// per cycle monitor
	//////////////////////////////

	// outputs sampled mid cycle, model then steps to the next edge
	task automatic monitor_cycle();
		int                  w;
		logic                exp_valid;
		command_tag_t        t;
		logic [CU_COUNT-1:0] exp_ready;
		if (uut.chk.failures != 0)
			stop_run("a bound assertion in the checker failed");
		for (int u = 0; u < CU_COUNT; u++) begin
			exp_ready[u] = !held[u];
			ready_now[u] = !held[u];
		end
		check_done(cu_req_ready, exp_ready, "cu_req_ready");
		w         = pick_winner();
		exp_valid = settled && (free_q.size() > 0) && (w >= 0);
		check_flag(command_valid, exp_valid, "command_valid");
		if (settled)
			check_flag(tags_ready, free_q.size() > 0, "tags_ready");
		check_done(response_done, exp_done, "response_done");
		if (exp_done != '0)
			check_type(response_type, exp_type, "response_type");
		// completion pulse is also the credit back
		for (int u = 0; u < CU_COUNT; u++)
			if (exp_done[u])
				outstanding[u]--;
		if (exp_valid) begin
			t = free_q.pop_front();
			check_tag(command_tag, t, "command");
			check_line(command_cu, command_type, cu_id_t'(w), held_type[w], "command owner");
			owner[t]       = {cu_id_t'(w), held_type[w]};
			issued[t]      = 1'b1;
			held[w]        = 1'b0;
			outstanding[w] = outstanding[w] + 1;
			rr             = (w + 1) % CU_COUNT;
		end
		exp_done = '0;
	endtask

	task automatic step();
		@(negedge clock);
		monitor_cycle();
		cu_req             = '0;
		tag_response_valid = 1'b0;
	endtask

	//////////////////////////////
	// trace operations
	//////////////////////////////

	task automatic drive_request(input int u, input int ty);
		while (!ready_now[u])
			step();
		cu_req[u]      = 1'b1;
		cu_req_type[u] = command_type_t'(ty);
		held[u]        = 1'b1;
		held_type[u]   = command_type_t'(ty);
	endtask

	task automatic drive_response(input int tg);
		command_tag_t t;
		cu_id_t       c;
		t = command_tag_t'(tg);
		if (!issued[t])
			stop_run("the trace returns a tag that is not outstanding");
		c                  = owner[t][line_cu_msb:line_type_msb+1];
		exp_done           = '0;
		exp_done[c]        = 1'b1;
		exp_type           = owner[t][line_type_msb:0];
		issued[t]          = 1'b0;
		tag_response_valid = 1'b1;
		response_tag       = t;
		free_q.push_back(t);
	endtask

	// combinational path, checked a moment after driving
	task automatic lookup(input int tg, input int c, input int ty);
		data_read_tag = command_tag_t'(tg);
		#1;
		check_line(data_read_cu, data_read_type, cu_id_t'(c), command_type_t'(ty),
			"data read lookup");
		step();
	endtask

	task automatic wait_cycles(input int n);
		int gap;
		gap = int'(lfsr_bit());
		gap = gap * 2 + int'(lfsr_bit());
		repeat (n + gap) step();
	endtask

	task automatic disable_pool();
		for (int u = 0; u < CU_COUNT; u++)
			if (outstanding[u] != 0 || held[u])
				stop_run("the trace drops enable with commands still outstanding");
		enabled_in = 1'b0;
		settled    = 1'b0;
		free_q.delete();
		repeat (4) step();
	endtask

	// pool rebuilt in order, issue restarts at tag 0
	task automatic enable_pool();
		int n;
		n          = 0;
		enabled_in = 1'b1;
		step();
		while (!tags_ready) begin
			if (n > TAG_COUNT + 8)
				stop_run("tags_ready did not rise after enable");
			step();
			n++;
		end
		for (int i = 0; i < TAG_COUNT; i++)
			free_q.push_back(command_tag_t'(i));
		settled = 1'b1;
	endtask

	task automatic read_trace();
		int    fd;
		int    r;
		byte   ch;
		string line;
		fd = $fopen("bench/tag_trace.txt", "r");
		if (fd == 0)
			stop_run("cannot open the trace file bench/tag_trace.txt");
		n_ops = 0;
		while (!$feof(fd) && n_ops < MAX_OPS) begin
			r = $fscanf(fd, " %c", ch);
			if (r != 1)
				break;
			op_code[n_ops] = ch;
			case (ch)
				"#":      r = $fgets(line, fd);
				"R":      r = $fscanf(fd, "%d %d", op_a[n_ops], op_b[n_ops]);
				"P", "W": r = $fscanf(fd, "%d", op_a[n_ops]);
				"L":      r = $fscanf(fd, "%d %d %d", op_a[n_ops], op_b[n_ops], op_c[n_ops]);
				"E", "D": r = 0;
				default:  stop_run("unknown opcode in the trace file");
			endcase
			if (ch != "#")
				n_ops++;
		end
		$fclose(fd);
	endtask

	// bound from trace length plus reset and pool init
	initial begin
		wait (loaded);
		#((n_ops * 64 + 5 + TAG_COUNT + 16) * PERIOD);
		stop_run("watchdog timeout, the trace did not finish in time");
	end

	initial begin
		rstn               = 1'b0;
		enabled_in         = 1'b0;
		cu_req             = '0;
		cu_req_type        = '0;
		tag_response_valid = 1'b0;
		response_tag       = '0;
		data_read_tag      = '0;
		lfsr               = 32'h1934_c6a4;
		settled            = 1'b0;
		rr                 = 0;
		exp_done           = '0;
		exp_type           = '0;
		failed             = 0;
		loaded             = 1'b0;
		for (int u = 0; u < CU_COUNT; u++) begin
			outstanding[u] = 0;
			held[u]        = 1'b0;
			held_type[u]   = '0;
			ready_now[u]   = 1'b1;
		end
		for (int t = 0; t < TAG_COUNT; t++) begin
			issued[t] = 1'b0;
			owner[t]  = '0;
		end
		read_trace();
		loaded = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		step();
		for (int i = 0; i < n_ops; i++) begin
			case (op_code[i])
				"E": enable_pool();
				"D": disable_pool();
				"R": drive_request(op_a[i], op_b[i]);
				"P": drive_response(op_a[i]);
				"L": lookup(op_a[i], op_b[i], op_c[i]);
				"W": wait_cycles(op_a[i]);
				default: stop_run("unknown opcode in the trace table");
			endcase
		end
		repeat (2) step();
		if (failed == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "simulation stopped");
		end
	end

endmodule

// ==== bench/tag_trace.txt ====
# E enable, D disable, R unit type, P tag, W cycles
# L tag unit type is a read lookup with the expected owner
E
R 0 1
R 1 2
R 2 1
R 3 2
W 6
L 2 2 1
L 3 3 2
R 1 1
R 0 2
W 4
L 4 0 2
L 5 1 1
P 1
W 3
R 0 1
W 3
R 0 0
W 4
R 2 2
W 3
R 3 1
W 3
R 1 0
W 4
P 0
W 4
L 0 1 0
P 4
W 4
L 4 0 0
P 2
W 1
P 3
W 1
P 5
W 1
P 6
W 1
P 7
W 1
P 1
W 1
P 0
W 1
P 4
W 3
D
E
R 2 1
W 3
L 0 2 1
R 3 2
W 3
L 1 3 2
W 2

// ==== tb.f ====
verilog/accel_pkg.sv
verilog/fifo.sv
verilog/ram_2xrd.sv
verilog/tag_control.sv
verilog/cu_credit_unit.sv
verilog/command_arbiter.sv
verilog/response_router.sv
verilog/tag_subsystem_top.sv
bench/tag_subsystem_chk.sv
bench/tb_tag_subsystem.sv

// ==== Makefile ====
TOP = tb_tag_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
